// File: logic/rv32i_consts.svh
// rv32i core constants
// reset vector, bubble encoding and register file depth
`ifndef RV32I_CONSTS_SVH
`define RV32I_CONSTS_SVH

`define RESET_PC  32'h0000_0000
`define NOP_INSTR 32'h0000_0013  // addi x0, x0, 0
`define NUM_REGS  32

`endif

// File: logic/rv32i_pkg.sv
// rv32i core types
// vector types, decode enums, control word and pipeline register layouts
package rv32i_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [3:0]  byte_en_t;

  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU,
    BR_JAL
  } br_op_e;

  // encoded as funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    MEM_BYTE = 2'b00,
    MEM_HALF = 2'b01,
    MEM_WORD = 2'b10
  } mem_size_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_PC4
  } wb_sel_e;

  typedef struct packed {
    alu_op_e   alu_op;
    logic      alu_src_imm;   // operand b from immediate
    logic      alu_src_pc;    // operand a from pc
    br_op_e    br_op;
    logic      mem_read;
    logic      mem_write;
    mem_size_e mem_size;
    logic      mem_unsigned;
    logic      reg_write;
    wb_sel_e   wb_sel;
  } ctrl_word_t;

  typedef struct packed {
    word_t pc;
    word_t instr;
    logic  valid;
  } if_id_t;

  typedef struct packed {
    word_t      pc;
    word_t      rs1_val;
    word_t      rs2_val;
    word_t      imm;
    reg_idx_t   rd;
    ctrl_word_t ctrl;
    logic       valid;
  } id_ex_t;

  typedef struct packed {
    word_t      pc;
    word_t      alu_result;
    word_t      store_val;
    reg_idx_t   rd;
    ctrl_word_t ctrl;
    logic       valid;
  } ex_mem_t;

  typedef struct packed {
    reg_idx_t rd;
    word_t    wb_val;
    logic     reg_write;
    logic     valid;
  } mem_wb_t;

endpackage

// File: logic/control_rom.sv
// instruction decoder
// maps opcode, funct3 and funct7 onto the pipeline control word
module control_rom (
  input  rv32i_pkg::word_t      instr,
  output rv32i_pkg::ctrl_word_t ctrl
);

  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       alt;      // funct7 selects sub / sra
  logic       reg_ok;
  logic       imm_ok;

  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign alt    = (funct7 == 7'b0100000);

  // alternate encoding only exists for add/sub and srl/sra
  assign reg_ok = (funct7 == 7'b0) || (alt && (funct3 == 3'b000 || funct3 == 3'b101));
  assign imm_ok = (funct3 != 3'b001 && funct3 != 3'b101) || (funct7 == 7'b0) ||
                  (alt && funct3 == 3'b101);

  function automatic rv32i_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic sub_sra);
    case (f3)
      3'b000:  return sub_sra ? rv32i_pkg::ALU_SUB : rv32i_pkg::ALU_ADD;
      3'b001:  return rv32i_pkg::ALU_SLL;
      3'b010:  return rv32i_pkg::ALU_SLT;
      3'b011:  return rv32i_pkg::ALU_SLTU;
      3'b100:  return rv32i_pkg::ALU_XOR;
      3'b101:  return sub_sra ? rv32i_pkg::ALU_SRA : rv32i_pkg::ALU_SRL;
      3'b110:  return rv32i_pkg::ALU_OR;
      default: return rv32i_pkg::ALU_AND;
    endcase
  endfunction

  always_comb begin
    ctrl          = '0;   // unknown encodings write nothing
    ctrl.alu_op   = rv32i_pkg::ALU_ADD;
    ctrl.br_op    = rv32i_pkg::BR_NONE;
    ctrl.mem_size = rv32i_pkg::MEM_WORD;
    ctrl.wb_sel   = rv32i_pkg::WB_ALU;
    case (rv32i_pkg::opcode_e'(instr[6:0]))
      rv32i_pkg::OP_LUI: begin
        ctrl.alu_src_imm = 1'b1;  // rs1 reads as x0
        ctrl.reg_write   = 1'b1;
      end
      rv32i_pkg::OP_AUIPC: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_src_pc  = 1'b1;
        ctrl.reg_write   = 1'b1;
      end
      rv32i_pkg::OP_JAL: begin
        ctrl.br_op     = rv32i_pkg::BR_JAL;
        ctrl.wb_sel    = rv32i_pkg::WB_PC4;
        ctrl.reg_write = 1'b1;
      end
      rv32i_pkg::OP_BRANCH: begin
        case (funct3)
          3'b000:  ctrl.br_op = rv32i_pkg::BR_EQ;
          3'b001:  ctrl.br_op = rv32i_pkg::BR_NE;
          3'b100:  ctrl.br_op = rv32i_pkg::BR_LT;
          3'b101:  ctrl.br_op = rv32i_pkg::BR_GE;
          3'b110:  ctrl.br_op = rv32i_pkg::BR_LTU;
          3'b111:  ctrl.br_op = rv32i_pkg::BR_GEU;
          default: ctrl.br_op = rv32i_pkg::BR_NONE;
        endcase
      end
      rv32i_pkg::OP_LOAD: begin
        if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
          ctrl.alu_src_imm  = 1'b1;
          ctrl.mem_read     = 1'b1;
          ctrl.mem_size     = rv32i_pkg::mem_size_e'(funct3[1:0]);
          ctrl.mem_unsigned = funct3[2];
          ctrl.reg_write    = 1'b1;
          ctrl.wb_sel       = rv32i_pkg::WB_MEM;
        end
      end
      rv32i_pkg::OP_STORE: begin
        if (funct3 inside {3'b000, 3'b001, 3'b010}) begin
          ctrl.alu_src_imm = 1'b1;
          ctrl.mem_write   = 1'b1;
          ctrl.mem_size    = rv32i_pkg::mem_size_e'(funct3[1:0]);
        end
      end
      rv32i_pkg::OP_IMM: begin
        if (imm_ok) begin
          ctrl.alu_op      = alu_decode(funct3, alt && funct3 == 3'b101);  // addi has no sub
          ctrl.alu_src_imm = 1'b1;
          ctrl.reg_write   = 1'b1;
        end
      end
      rv32i_pkg::OP_REG: begin
        if (reg_ok) begin
          ctrl.alu_op    = alu_decode(funct3, alt);
          ctrl.reg_write = 1'b1;
        end
      end
      default: ;
    endcase
  end

endmodule

// File: logic/regfile.sv
// integer register file
// two combinational read ports with writeback bypass, x0 reads as zero
`include "rv32i_consts.svh"

module regfile (
  input  logic                clk,
  input  logic                rst_n,
  input  rv32i_pkg::reg_idx_t rs1_idx,
  input  rv32i_pkg::reg_idx_t rs2_idx,
  output rv32i_pkg::word_t    rs1_val,
  output rv32i_pkg::word_t    rs2_val,
  input  rv32i_pkg::mem_wb_t  wb
);

  rv32i_pkg::word_t regs [`NUM_REGS];
  logic             wr_en;

  assign wr_en = wb.valid && wb.reg_write && (wb.rd != '0);  // x0 never written

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb.rd] <= wb.wb_val;
    end
  end

  function automatic rv32i_pkg::word_t read_port(input rv32i_pkg::reg_idx_t idx);
    if (idx == '0) return '0;
    if (wr_en && wb.rd == idx) return wb.wb_val;  // same-cycle writeback
    return regs[idx];
  endfunction

  always_comb begin
    rs1_val = read_port(rs1_idx);
    rs2_val = read_port(rs2_idx);
  end

endmodule

// File: logic/fetch_stage.sv
// instruction fetch
// keeps the pc, strobes the instruction port and fills the IF/ID register
`include "rv32i_consts.svh"

module fetch_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              stall,
  input  logic              redirect,
  input  rv32i_pkg::word_t  redirect_pc,
  output rv32i_pkg::word_t  icache_address,
  output logic              icache_read,
  input  rv32i_pkg::word_t  icache_rdata,
  output rv32i_pkg::if_id_t if_id
);

  rv32i_pkg::word_t pc;
  logic             running;  // low until the first edge out of reset

  assign icache_address = pc;
  assign icache_read    = running && !stall;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc      <= `RESET_PC;
      running <= 1'b0;
    end else begin
      running <= 1'b1;
      if (redirect) begin
        pc <= redirect_pc;  // wins over a stall
      end else if (icache_read) begin
        pc <= pc + 32'd4;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      if_id.valid <= 1'b0;
    end else if (redirect) begin
      if_id.instr <= `NOP_INSTR;  // wrong-path slot
      if_id.valid <= 1'b0;
    end else if (!stall) begin
      if_id.pc    <= pc;
      if_id.instr <= icache_rdata;
      if_id.valid <= running;
    end
  end

endmodule

// File: logic/decode_stage.sv
// instruction decode
// register read, immediate build, RAW hazard stall and the ID/EX register
module decode_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  rv32i_pkg::if_id_t   if_id,
  input  rv32i_pkg::ex_mem_t  ex_mem,
  input  logic                redirect,
  output rv32i_pkg::reg_idx_t rs1_idx,
  output rv32i_pkg::reg_idx_t rs2_idx,
  input  rv32i_pkg::word_t    rs1_val,
  input  rv32i_pkg::word_t    rs2_val,
  output logic                stall,
  output rv32i_pkg::id_ex_t   id_ex
);

  rv32i_pkg::ctrl_word_t ctrl;
  rv32i_pkg::opcode_e    opcode;
  rv32i_pkg::word_t      instr;
  rv32i_pkg::word_t      imm;
  logic                  use_rs1;
  logic                  use_rs2;
  logic                  hit_ex;
  logic                  hit_mem;

  assign instr  = if_id.instr;
  assign opcode = rv32i_pkg::opcode_e'(instr[6:0]);

  control_rom ctrl_rom (
    .instr(instr),
    .ctrl (ctrl)
  );

  assign use_rs1 = opcode inside {rv32i_pkg::OP_REG, rv32i_pkg::OP_IMM, rv32i_pkg::OP_LOAD,
                                  rv32i_pkg::OP_STORE, rv32i_pkg::OP_BRANCH};
  assign use_rs2 = opcode inside {rv32i_pkg::OP_REG, rv32i_pkg::OP_STORE, rv32i_pkg::OP_BRANCH};

  // unused sources read x0, so lui gets a zero operand and no false hazard
  assign rs1_idx = use_rs1 ? instr[19:15] : '0;
  assign rs2_idx = use_rs2 ? instr[24:20] : '0;

  always_comb begin
    case (opcode)
      rv32i_pkg::OP_STORE:  imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
      rv32i_pkg::OP_BRANCH: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      rv32i_pkg::OP_LUI,
      rv32i_pkg::OP_AUIPC:  imm = {instr[31:12], 12'b0};
      rv32i_pkg::OP_JAL:    imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      default:              imm = {{21{instr[31]}}, instr[30:20]};  // I-type
    endcase
  end

  function automatic logic raw_hit(input logic writes, input rv32i_pkg::reg_idx_t rd,
                                   input rv32i_pkg::reg_idx_t a, input rv32i_pkg::reg_idx_t b);
    return writes && ((a != '0 && rd == a) || (b != '0 && rd == b));
  endfunction

  // WB is covered by the regfile bypass
  always_comb begin
    hit_ex  = raw_hit(id_ex.valid && id_ex.ctrl.reg_write, id_ex.rd, rs1_idx, rs2_idx);
    hit_mem = raw_hit(ex_mem.valid && ex_mem.ctrl.reg_write, ex_mem.rd, rs1_idx, rs2_idx);
    stall   = if_id.valid && (hit_ex || hit_mem);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_ex.valid <= 1'b0;
    end else begin
      id_ex.pc      <= if_id.pc;
      id_ex.rs1_val <= rs1_val;
      id_ex.rs2_val <= rs2_val;
      id_ex.imm     <= imm;
      id_ex.rd      <= instr[11:7];
      id_ex.ctrl    <= ctrl;
      id_ex.valid   <= if_id.valid && !stall && !redirect;  // bubble on stall or flush
    end
  end

endmodule

// File: logic/execute_stage.sv
// execute
// ALU, branch compare and redirect, then the EX/MEM register
module execute_stage (
  input  logic               clk,
  input  logic               rst_n,
  input  rv32i_pkg::id_ex_t  id_ex,
  output logic               redirect,
  output rv32i_pkg::word_t   redirect_pc,
  output rv32i_pkg::ex_mem_t ex_mem
);

  rv32i_pkg::word_t op_a;
  rv32i_pkg::word_t op_b;
  rv32i_pkg::word_t alu_result;
  logic             taken;

  assign op_a = id_ex.ctrl.alu_src_pc  ? id_ex.pc  : id_ex.rs1_val;
  assign op_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : id_ex.rs2_val;

  always_comb begin
    case (id_ex.ctrl.alu_op)
      rv32i_pkg::ALU_SUB:  alu_result = op_a - op_b;
      rv32i_pkg::ALU_AND:  alu_result = op_a & op_b;
      rv32i_pkg::ALU_OR:   alu_result = op_a | op_b;
      rv32i_pkg::ALU_XOR:  alu_result = op_a ^ op_b;
      rv32i_pkg::ALU_SLL:  alu_result = op_a << op_b[4:0];
      rv32i_pkg::ALU_SRL:  alu_result = op_a >> op_b[4:0];
      rv32i_pkg::ALU_SRA:  alu_result = rv32i_pkg::word_t'($signed(op_a) >>> op_b[4:0]);
      rv32i_pkg::ALU_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      rv32i_pkg::ALU_SLTU: alu_result = {31'b0, op_a < op_b};
      default:             alu_result = op_a + op_b;
    endcase
  end

  // compare always works on the register values
  always_comb begin
    case (id_ex.ctrl.br_op)
      rv32i_pkg::BR_EQ:  taken = (id_ex.rs1_val == id_ex.rs2_val);
      rv32i_pkg::BR_NE:  taken = (id_ex.rs1_val != id_ex.rs2_val);
      rv32i_pkg::BR_LT:  taken = ($signed(id_ex.rs1_val) < $signed(id_ex.rs2_val));
      rv32i_pkg::BR_GE:  taken = ($signed(id_ex.rs1_val) >= $signed(id_ex.rs2_val));
      rv32i_pkg::BR_LTU: taken = (id_ex.rs1_val < id_ex.rs2_val);
      rv32i_pkg::BR_GEU: taken = (id_ex.rs1_val >= id_ex.rs2_val);
      rv32i_pkg::BR_JAL: taken = 1'b1;
      default:           taken = 1'b0;
    endcase
  end

  assign redirect    = id_ex.valid && taken;
  assign redirect_pc = id_ex.pc + id_ex.imm;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_mem.valid <= 1'b0;
    end else begin
      ex_mem.pc         <= id_ex.pc;   // for the jal link value
      ex_mem.alu_result <= alu_result;
      ex_mem.store_val  <= id_ex.rs2_val;
      ex_mem.rd         <= id_ex.rd;
      ex_mem.ctrl       <= id_ex.ctrl;
      ex_mem.valid      <= id_ex.valid;
    end
  end

endmodule

// File: logic/memory_stage.sv
// memory access
// drives the data port, aligns lanes, extends loads and picks the writeback value
module memory_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  rv32i_pkg::ex_mem_t  ex_mem,
  output rv32i_pkg::word_t    dcache_address,
  output rv32i_pkg::word_t    dcache_wdata,
  output rv32i_pkg::byte_en_t dcache_byte_enable,
  output logic                dcache_read,
  output logic                dcache_write,
  input  rv32i_pkg::word_t    dcache_rdata,
  output rv32i_pkg::mem_wb_t  wb
);

  logic [1:0]       offset;
  logic [4:0]       lane_shift;  // offset in bits
  logic             sext;
  rv32i_pkg::word_t lane_data;
  rv32i_pkg::word_t load_val;
  rv32i_pkg::word_t wb_val;

  assign offset         = ex_mem.alu_result[1:0];
  assign lane_shift     = {offset, 3'b000};
  assign sext           = !ex_mem.ctrl.mem_unsigned;
  assign dcache_address = {ex_mem.alu_result[31:2], 2'b00};
  assign dcache_read    = ex_mem.valid && ex_mem.ctrl.mem_read;
  assign dcache_write   = ex_mem.valid && ex_mem.ctrl.mem_write;
  assign dcache_wdata   = ex_mem.store_val << lane_shift;
  assign lane_data      = dcache_rdata >> lane_shift;  // addressed byte to bit 0

  always_comb begin
    case (ex_mem.ctrl.mem_size)
      rv32i_pkg::MEM_BYTE: begin
        dcache_byte_enable = 4'b0001 << offset;
        load_val           = {{24{sext && lane_data[7]}}, lane_data[7:0]};
      end
      rv32i_pkg::MEM_HALF: begin
        dcache_byte_enable = 4'b0011 << offset;
        load_val           = {{16{sext && lane_data[15]}}, lane_data[15:0]};
      end
      default: begin
        dcache_byte_enable = 4'b1111;
        load_val           = dcache_rdata;
      end
    endcase
  end

  always_comb begin
    case (ex_mem.ctrl.wb_sel)
      rv32i_pkg::WB_MEM: wb_val = load_val;
      rv32i_pkg::WB_PC4: wb_val = ex_mem.pc + 32'd4;
      default:           wb_val = ex_mem.alu_result;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb.reg_write <= 1'b0;
      wb.valid     <= 1'b0;
    end else begin
      wb.rd        <= ex_mem.rd;
      wb.wb_val    <= wb_val;
      wb.reg_write <= ex_mem.valid && ex_mem.ctrl.reg_write;
      wb.valid     <= ex_mem.valid;
    end
  end

endmodule

// File: logic/rv32i_core.sv
// rv32i five-stage core
// in-order pipeline with decode stalls for hazards and branches resolved in EX
module rv32i_core (
  input  logic                clk,
  input  logic                rst_n,

  // instruction port
  output rv32i_pkg::word_t    icache_address,
  output logic                icache_read,
  input  rv32i_pkg::word_t    icache_rdata,

  // data port
  output rv32i_pkg::word_t    dcache_address,
  output rv32i_pkg::word_t    dcache_wdata,
  output rv32i_pkg::byte_en_t dcache_byte_enable,
  output logic                dcache_read,
  output logic                dcache_write,
  input  rv32i_pkg::word_t    dcache_rdata
);

  rv32i_pkg::if_id_t   if_id;
  rv32i_pkg::id_ex_t   id_ex;
  rv32i_pkg::ex_mem_t  ex_mem;
  rv32i_pkg::mem_wb_t  wb;
  rv32i_pkg::reg_idx_t rs1_idx;
  rv32i_pkg::reg_idx_t rs2_idx;
  rv32i_pkg::word_t    rs1_val;
  rv32i_pkg::word_t    rs2_val;
  rv32i_pkg::word_t    redirect_pc;
  logic                stall;
  logic                redirect;

  fetch_stage fetch (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall         (stall),
    .redirect      (redirect),
    .redirect_pc   (redirect_pc),
    .icache_address(icache_address),
    .icache_read   (icache_read),
    .icache_rdata  (icache_rdata),
    .if_id         (if_id)
  );

  decode_stage decode (
    .clk     (clk),
    .rst_n   (rst_n),
    .if_id   (if_id),
    .ex_mem  (ex_mem),
    .redirect(redirect),
    .rs1_idx (rs1_idx),
    .rs2_idx (rs2_idx),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .stall   (stall),
    .id_ex   (id_ex)
  );

  execute_stage execute (
    .clk        (clk),
    .rst_n      (rst_n),
    .id_ex      (id_ex),
    .redirect   (redirect),
    .redirect_pc(redirect_pc),
    .ex_mem     (ex_mem)
  );

  memory_stage memory (
    .clk               (clk),
    .rst_n             (rst_n),
    .ex_mem            (ex_mem),
    .dcache_address    (dcache_address),
    .dcache_wdata      (dcache_wdata),
    .dcache_byte_enable(dcache_byte_enable),
    .dcache_read       (dcache_read),
    .dcache_write      (dcache_write),
    .dcache_rdata      (dcache_rdata),
    .wb                (wb)
  );

  regfile regs (
    .clk    (clk),
    .rst_n  (rst_n),
    .rs1_idx(rs1_idx),
    .rs2_idx(rs2_idx),
    .rs1_val(rs1_val),
    .rs2_val(rs2_val),
    .wb     (wb)
  );

endmodule

// File: tests/rv32i_core_properties.sv
// assertions bound into the rv32i core
// data port strobes, reset behaviour, x0 and the redirect flush
module rv32i_core_properties (
  input logic             clk,
  input logic             rst_n,
  input logic             icache_read,
  input rv32i_pkg::word_t icache_address,
  input logic             dcache_read,
  input logic             dcache_write,
  input logic             redirect,
  input rv32i_pkg::word_t redirect_pc,
  input logic             if_id_valid,
  input logic             id_ex_valid,
  input rv32i_pkg::word_t x0_val
);

  read_write_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(dcache_read && dcache_write))
    else $error("dcache_read and dcache_write high in the same cycle");

  // strobes stay low in every cycle that follows a reset edge
  strobes_low_in_reset: assert property (@(posedge clk)
    !rst_n |=> !icache_read && !dcache_read && !dcache_write)
    else $error("memory strobe high while the core is held in reset");

  x0_stays_zero: assert property (@(posedge clk) disable iff (!rst_n)
    x0_val == '0)
    else $error("register x0 holds a non-zero value");

  // next cycle fetch sits on the target and both younger slots are empty
  redirect_flushes: assert property (@(posedge clk) disable iff (!rst_n)
    redirect |=> icache_address == $past(redirect_pc) && !if_id_valid && !id_ex_valid)
    else $error("redirect did not steer fetch or flush the younger instructions");

endmodule

bind rv32i_core rv32i_core_properties props (
  .clk           (clk),
  .rst_n         (rst_n),
  .icache_read   (icache_read),
  .icache_address(icache_address),
  .dcache_read   (dcache_read),
  .dcache_write  (dcache_write),
  .redirect      (redirect),
  .redirect_pc   (redirect_pc),
  .if_id_valid   (if_id.valid),
  .id_ex_valid   (id_ex.valid),
  .x0_val        (regs.regs[0])
);

// File: tests/rv32i_core_tb.sv
// testbench for the rv32i five-stage core
// runs the program from the vectors file and checks every data store
`include "rv32i_consts.svh"

module rv32i_core_tb;

  localparam int VEC_DEPTH    = 512;
  localparam int DMEM_WORDS   = 256;
  localparam int LOAD_IDX     = 32;          // word at byte address 0x80
  localparam int DRAIN_CYCLES = 8;           // pipeline depth plus margin
  localparam rv32i_pkg::word_t LOAD_WORD = 32'h80F1_7F82;

  logic                clk;
  logic                rst_n;
  rv32i_pkg::word_t    icache_address;
  logic                icache_read;
  rv32i_pkg::word_t    icache_rdata;
  rv32i_pkg::word_t    dcache_address;
  rv32i_pkg::word_t    dcache_wdata;
  rv32i_pkg::byte_en_t dcache_byte_enable;
  logic                dcache_read;
  logic                dcache_write;
  rv32i_pkg::word_t    dcache_rdata;

  rv32i_pkg::word_t vectors [VEC_DEPTH];
  rv32i_pkg::word_t dmem [DMEM_WORDS];
  int prog_len;
  int store_count;
  int store_base;                            // index of the first store record
  int cycle_limit;
  int cycles;
  int fetch_idx;
  int errors = 0;
  int stores_checked = 0;

  // store seen at the falling edge, committed at the next rising edge
  logic                pend_valid;
  logic [7:0]          pend_idx;
  rv32i_pkg::word_t    pend_data;
  rv32i_pkg::byte_en_t pend_be;

  rv32i_core UUT (
    .clk               (clk),
    .rst_n             (rst_n),
    .icache_address    (icache_address),
    .icache_read       (icache_read),
    .icache_rdata      (icache_rdata),
    .dcache_address    (dcache_address),
    .dcache_wdata      (dcache_wdata),
    .dcache_byte_enable(dcache_byte_enable),
    .dcache_read       (dcache_read),
    .dcache_write      (dcache_write),
    .dcache_rdata      (dcache_rdata)
  );

  always #2 clk = ~clk;

  // both memories answer in the same cycle and only when strobed
  assign fetch_idx    = int'(icache_address >> 2);
  assign icache_rdata = (icache_read && fetch_idx < prog_len) ?
                        vectors[fetch_idx + 1] : `NOP_INSTR;
  assign dcache_rdata = dcache_read ? dmem[dcache_address[9:2]] : '0;

  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        dmem[i] <= (i == LOAD_IDX) ? LOAD_WORD : (32'hDA7A_0000 | i);
      end
    end else if (pend_valid) begin
      for (int b = 0; b < 4; b++) begin
        if (pend_be[b]) begin
          dmem[pend_idx][8*b +: 8] <= pend_data[8*b +: 8];
        end
      end
    end
  end

  function automatic rv32i_pkg::word_t byte_mask(input rv32i_pkg::byte_en_t be);
    rv32i_pkg::word_t m;
    for (int b = 0; b < 4; b++) begin
      m[8*b +: 8] = {8{be[b]}};
    end
    return m;
  endfunction

  task automatic load_vectors();
    for (int i = 0; i < VEC_DEPTH; i++) begin
      vectors[i] = '0;
    end
    $readmemh("tests/program_vectors.hex", vectors);
    prog_len    = int'(vectors[0]);
    store_count = int'(vectors[prog_len + 1]);
    store_base  = prog_len + 2;
    cycle_limit = 8 * prog_len + 100;
  endtask

  task automatic check_store(input rv32i_pkg::word_t addr, input rv32i_pkg::word_t data,
                             input rv32i_pkg::byte_en_t be);
    int                  rec;
    rv32i_pkg::word_t    exp_addr;
    rv32i_pkg::word_t    exp_data;
    rv32i_pkg::word_t    mask;
    rv32i_pkg::byte_en_t exp_be;
    if (stores_checked >= store_count) begin
      $display("unexpected store to %08h after all %0d expected stores", addr, store_count);
      errors++;
      return;
    end
    rec      = store_base + 3 * stores_checked;
    exp_addr = vectors[rec];
    exp_data = vectors[rec + 1];
    exp_be   = vectors[rec + 2][3:0];
    mask     = byte_mask(exp_be);               // lanes outside the enables are don't care
    if (addr !== exp_addr) begin
      $display("ERROR store %0d address: expected %08h, actual %08h",
               stores_checked, exp_addr, addr);
      errors++;
    end
    if (be !== exp_be) begin
      $display("ERROR store %0d byte enable: expected %h, actual %h",
               stores_checked, exp_be, be);
      errors++;
    end
    if ((data & mask) !== (exp_data & mask)) begin
      $display("ERROR store %0d data: expected %08h, actual %08h",
               stores_checked, exp_data & mask, data & mask);
      errors++;
    end
    stores_checked++;
  endtask

  always @(negedge clk) begin
    pend_valid <= rst_n && dcache_write;
    pend_idx   <= dcache_address[9:2];
    pend_data  <= dcache_wdata;
    pend_be    <= dcache_byte_enable;
    if (rst_n && dcache_write) begin
      check_store(dcache_address, dcache_wdata, dcache_byte_enable);
    end
  end

  initial begin
    int missing;
    clk    = 1'b0;
    rst_n  = 1'b0;
    cycles = 0;
    load_vectors();
    if (prog_len == 0 || store_count == 0) begin
      $display("vectors file gave no program or no expected stores");
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    while (stores_checked < store_count && cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    if (stores_checked == store_count) begin
      repeat (DRAIN_CYCLES) @(posedge clk);  // parked loop retires, stray stores still seen
    end
    missing = store_count - stores_checked;
    if (missing > 0) begin
      $display("timeout after %0d cycles, %0d expected stores never appeared", cycles, missing);
    end
    $display("errors: %0d  stores checked: %0d of %0d  missing: %0d",
             errors, stores_checked, store_count, missing);
    if (errors == 0 && missing <= 0 && store_count > 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: tests/program_vectors.hex
// word 0: program length, then one instruction word per line from address 0
// after the program: store count, then records of address, lane data, byte enable
00000042
123450b7  // 00 lui   x1, 0x12345
ffb00113  // 04 addi  x2, x0, -5
00300193  // 08 addi  x3, x0, 3
00208233  // 0c add   x4, x1, x2
10402023  // 10 sw    x4, 0x100(x0)
402182b3  // 14 sub   x5, x3, x2
10502223  // 18 sw    x5, 0x104(x0)
0f017313  // 1c andi  x6, x2, 0x0f0
10602423  // 20 sw    x6, 0x108(x0)
0030e3b3  // 24 or    x7, x1, x3
10702623  // 28 sw    x7, 0x10c(x0)
55514413  // 2c xori  x8, x2, 0x555
10802823  // 30 sw    x8, 0x110(x0)
003094b3  // 34 sll   x9, x1, x3
10902a23  // 38 sw    x9, 0x114(x0)
00315533  // 3c srl   x10, x2, x3
10a02c23  // 40 sw    x10, 0x118(x0)
40115593  // 44 srai  x11, x2, 1
10b02e23  // 48 sw    x11, 0x11c(x0)
00312633  // 4c slt   x12, x2, x3
12c02023  // 50 sw    x12, 0x120(x0)
003136b3  // 54 sltu  x13, x2, x3
12d02223  // 58 sw    x13, 0x124(x0)
00001717  // 5c auipc x14, 0x1
12e02423  // 60 sw    x14, 0x128(x0)
12102623  // 64 sw    x1, 0x12c(x0)
00700793  // 68 addi  x15, x0, 7      dependent chain starts
00f78833  // 6c add   x16, x15, x15
403808b3  // 70 sub   x17, x16, x3
00289913  // 74 slli  x18, x17, 2
13202823  // 78 sw    x18, 0x130(x0)
00318463  // 7c beq   x3, x3, +8      taken
1e202823  // 80 sw    x2, 0x1f0(x0)   flushed
00319463  // 84 bne   x3, x3, +8      not taken
12302a23  // 88 sw    x3, 0x134(x0)
00314463  // 8c blt   x2, x3, +8      taken
1e202823  // 90 sw    x2, 0x1f0(x0)   flushed
00315463  // 94 bge   x2, x3, +8      not taken
12202c23  // 98 sw    x2, 0x138(x0)
00316463  // 9c bltu  x2, x3, +8      not taken
12c02e23  // a0 sw    x12, 0x13c(x0)
00317463  // a4 bgeu  x2, x3, +8      taken
1e202823  // a8 sw    x2, 0x1f0(x0)   flushed
00c009ef  // ac jal   x19, +12
1e202823  // b0 sw    x2, 0x1f0(x0)   flushed
1e202823  // b4 sw    x2, 0x1f0(x0)   skipped
15302023  // b8 sw    x19, 0x140(x0)
08000a03  // bc lb    x20, 0x80(x0)
15402223  // c0 sw    x20, 0x144(x0)
08304a83  // c4 lbu   x21, 0x83(x0)
15502423  // c8 sw    x21, 0x148(x0)
08201b03  // cc lh    x22, 0x82(x0)
15602623  // d0 sw    x22, 0x14c(x0)
08205b83  // d4 lhu   x23, 0x82(x0)
15702823  // d8 sw    x23, 0x150(x0)
08001c03  // dc lh    x24, 0x80(x0)
15802a23  // e0 sw    x24, 0x154(x0)
16800023  // e4 sb    x8, 0x160(x0)
168000a3  // e8 sb    x8, 0x161(x0)
16800123  // ec sb    x8, 0x162(x0)
168001a3  // f0 sb    x8, 0x163(x0)
16801223  // f4 sh    x8, 0x164(x0)
16801323  // f8 sh    x8, 0x166(x0)
16002c83  // fc lw    x25, 0x160(x0)
15902c23  // 100 sw   x25, 0x158(x0)
0000006f  // 104 jal  x0, 0         park here
0000001d
00000100 12344ffb f  // add
00000104 00000008 f  // sub
00000108 000000f0 f  // andi
0000010c 12345003 f  // or
00000110 fffffaae f  // xori
00000114 91a28000 f  // sll
00000118 1fffffff f  // srl
0000011c fffffffd f  // srai
00000120 00000001 f  // slt
00000124 00000000 f  // sltu
00000128 0000105c f  // auipc
0000012c 12345000 f  // lui
00000130 0000002c f  // dependent chain
00000134 00000003 f  // bne fall-through
00000138 fffffffb f  // bge fall-through
0000013c 00000001 f  // bltu fall-through
00000140 000000b0 f  // jal link
00000144 ffffff82 f  // lb
00000148 00000080 f  // lbu
0000014c ffff80f1 f  // lh offset 2
00000150 000080f1 f  // lhu offset 2
00000154 00007f82 f  // lh offset 0
00000160 000000ae 1  // sb lane 0
00000160 0000ae00 2  // sb lane 1
00000160 00ae0000 4  // sb lane 2
00000160 ae000000 8  // sb lane 3
00000164 0000faae 3  // sh low half
00000164 faae0000 c  // sh high half
00000158 aeaeaeae f  // word read back after byte stores

// File: files.f
+incdir+logic
logic/rv32i_pkg.sv
logic/control_rom.sv
logic/regfile.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/rv32i_core.sv
tests/rv32i_core_properties.sv
tests/rv32i_core_tb.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert
TOP       := rv32i_core_tb
FILELIST  := files.f
PASS_MSG  := *** PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir
